// ==== tile_defs.svh ====
/*
 * Compute tile widths, counts, address map and memory sizes
 */

`ifndef TILE_DEFS_SVH
`define TILE_DEFS_SVH

`define TILE_DW            32
`define TILE_NUM_MASTERS   2
`define TILE_NUM_SLAVES    3

`define TILE_SRAM_WORDS    256
`define TILE_ROM_WORDS     16
`define TILE_NOC_CREDITS   4              // Also the receive FIFO depth

`define TILE_SRAM_MATCH    4'h0           // Top address nibble per region
`define TILE_NA_MATCH      4'he
`define TILE_ROM_MATCH     4'hf
`define TILE_BOOT_MAGIC    32'hb007_0000

`define TILE_NA_TX_OFS     0              // Mailbox register offsets
`define TILE_NA_RX_OFS     4
`define TILE_NA_STAT_OFS   8

`endif

// ==== tile_pkg.sv ====
/*
 * Tile bus request and response structs, NoC flit struct
 * and the slave index enum
 */

`include "tile_defs.svh"

package tile_pkg;

   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [`TILE_DW-1:0]   adr;
      logic [`TILE_DW/8-1:0] sel;              // One bit per byte lane
      logic [`TILE_DW-1:0]   dat;              // Write data
   } wb_req_t;

   typedef struct packed {
      logic                ack;
      logic                err;
      logic [`TILE_DW-1:0] dat;                // Read data
   } wb_rsp_t;

   typedef struct packed {
      logic                valid;
      logic [`TILE_DW-1:0] data;
   } noc_flit_t;

   typedef enum logic [1:0] {
      SLV_SRAM = 2'd0,
      SLV_NA   = 2'd1,
      SLV_ROM  = 2'd2
   } slave_e;

endpackage

// ==== tile_bus.sv ====
/*
 * Shared tile bus with round-robin master arbitration,
 * address decode, response routing and unmapped-access error
 */

`include "tile_defs.svh"

module tile_bus (
   input  logic                                       clk,
   input  logic                                       reset_i,
   input  tile_pkg::wb_req_t [`TILE_NUM_MASTERS-1:0]  m_req_i,
   output tile_pkg::wb_rsp_t [`TILE_NUM_MASTERS-1:0]  m_rsp_o,
   output tile_pkg::wb_req_t [`TILE_NUM_SLAVES-1:0]   s_req_o,
   input  tile_pkg::wb_rsp_t [`TILE_NUM_SLAVES-1:0]   s_rsp_i
);

   localparam int NM = `TILE_NUM_MASTERS;
   localparam int NS = `TILE_NUM_SLAVES;
   localparam int MW = (NM > 1) ? $clog2(NM) : 1;

   logic              gnt_q;                    // A grant is held
   logic [MW-1:0]     last_q;                   // Current or last winner
   logic              nxt_found;
   logic [MW-1:0]     nxt_idx;
   logic              bus_err_q;
   logic [3:0]        nib;
   logic [NS-1:0]     hit;
   logic [NS-1:0]     slv_rsp;                  // Slave raises ack or err
   tile_pkg::wb_req_t cur_req;
   tile_pkg::wb_rsp_t cur_rsp;

   assign cur_req = m_req_i[last_q];
   assign nib     = cur_req.adr[`TILE_DW-1 -: 4];

   // Next requester after the last winner
   always_comb begin
      int unsigned idx;
      nxt_found = 1'b0;
      nxt_idx   = last_q;
      for (int i = 1; i <= NM; i++) begin
         idx = (int'(last_q) + i) % NM;
         if (!nxt_found && m_req_i[idx].cyc && m_req_i[idx].stb) begin
            nxt_found = 1'b1;
            nxt_idx   = MW'(idx);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         gnt_q  <= 1'b0;
         last_q <= MW'(NM - 1);                  // Master 0 wins first
      end else if (!gnt_q) begin
         if (nxt_found) begin
            gnt_q  <= 1'b1;
            last_q <= nxt_idx;
         end
      end else if (!cur_req.cyc) begin
         gnt_q <= 1'b0;                          // Master ended its cycle
      end
   end

   always_comb begin
      hit = '0;
      hit[tile_pkg::SLV_SRAM] = (nib == `TILE_SRAM_MATCH);
      hit[tile_pkg::SLV_NA]   = (nib == `TILE_NA_MATCH);
      hit[tile_pkg::SLV_ROM]  = (nib == `TILE_ROM_MATCH);
   end

   // Only the decoded slave sees cyc and stb
   always_comb begin
      for (int s = 0; s < NS; s++) begin
         s_req_o[s]     = cur_req;
         s_req_o[s].cyc = gnt_q && cur_req.cyc && hit[s];
         s_req_o[s].stb = gnt_q && cur_req.stb && hit[s];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         bus_err_q <= 1'b0;
      end else begin
         bus_err_q <= gnt_q && cur_req.cyc && cur_req.stb && (hit == '0) && !bus_err_q;
      end
   end

   always_comb begin
      cur_rsp = '0;
      for (int s = 0; s < NS; s++) begin
         slv_rsp[s] = s_rsp_i[s].ack || s_rsp_i[s].err;
         if (hit[s]) begin
            cur_rsp = s_rsp_i[s];
         end
      end
      if (bus_err_q) begin
         cur_rsp.err = 1'b1;
      end
   end

   always_comb begin
      for (int m = 0; m < NM; m++) begin
         m_rsp_o[m] = '0;                        // Waiting masters see nothing
         if (gnt_q && (last_q == MW'(m))) begin
            m_rsp_o[m] = cur_rsp;
         end
      end
   end

   // Only the one strobed slave may answer
   a_one_slave_rsp: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0(slv_rsp));

   // Master must hold its address until ack or err
   a_adr_stable: assert property (@(posedge clk) disable iff (reset_i)
      gnt_q && cur_req.cyc && cur_req.stb && !(cur_rsp.ack || cur_rsp.err)
      |=> $stable(cur_req.adr));

endmodule

// ==== tile_sram.sv ====
/*
 * Local data memory, word addressed, byte-select writes
 */

`include "tile_defs.svh"

module tile_sram (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   localparam int IW = $clog2(`TILE_SRAM_WORDS);

   logic [`TILE_DW-1:0] mem [`TILE_SRAM_WORDS];
   logic [`TILE_DW-1:0] dat_q;
   logic                ack_q;
   logic [IW-1:0]       idx;
   logic                go;

   assign idx = req_i.adr[IW+1:2];                 // Aliases past the array size
   assign go  = req_i.cyc && req_i.stb && !ack_q;  // One ack per strobe

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= go;
      end
   end

   always_ff @(posedge clk) begin
      if (go && req_i.we) begin
         for (int b = 0; b < `TILE_DW/8; b++) begin
            if (req_i.sel[b]) begin
               mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
            end
         end
      end
      if (go) begin
         dat_q <= mem[idx];                        // Whole word on reads
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;
   assign rsp_o.dat = dat_q;

endmodule

// ==== boot_rom.sv ====
/*
 * Boot ROM with a rule-generated image, writes get err
 */

`include "tile_defs.svh"

module boot_rom (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   localparam int KW = $clog2(`TILE_ROM_WORDS);

   logic                ack_q;
   logic                err_q;
   logic [`TILE_DW-1:0] dat_q;
   logic [KW-1:0]       k;
   logic                go;

   assign k  = req_i.adr[KW+1:2];                   // Word index modulo ROM size
   assign go = req_i.cyc && req_i.stb && !(ack_q || err_q);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= go && !req_i.we;
         err_q <= go && req_i.we;                    // Read only
      end
   end

   always_ff @(posedge clk) begin
      dat_q <= `TILE_BOOT_MAGIC | `TILE_DW'(k);
   end

   assign rsp_o = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

// ==== flit_fifo.sv ====
/*
 * Synchronous circular FIFO for received NoC flits
 */

`include "tile_defs.svh"

module flit_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                         clk,
   input  logic                         reset_i,
   input  tile_pkg::noc_flit_t          push_i,
   input  logic                         pop_i,
   output logic [`TILE_DW-1:0]          head_o,
   output logic                         empty_o,
   output logic [$clog2(DEPTH+1)-1:0]   count_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [`TILE_DW-1:0] mem [DEPTH];
   logic [AW-1:0]       rd_ptr_q;
   logic [AW-1:0]       wr_ptr_q;
   logic [CW-1:0]       count_q;
   logic                full;
   logic                push;
   logic                pop;

   assign empty_o = (count_q == '0);
   assign full    = (count_q == CW'(DEPTH));
   assign push    = push_i.valid && !full;
   assign pop     = pop_i && !empty_o;
   assign head_o  = mem[rd_ptr_q];
   assign count_o = count_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CW'(push) - CW'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= push_i.data;
      end
   end

   // Sender must respect its credits, reader must check empty
   a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
      full |-> !push_i.valid);
   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_i)
      empty_o |-> !pop_i);

endmodule

// ==== na_mailbox.sv ====
/*
 * Network adapter mailbox: TX, RX and status registers,
 * transmit credit counter, receive FIFO and credit return
 */

`include "tile_defs.svh"

module na_mailbox (
   input  logic                clk,
   input  logic                reset_i,
   input  tile_pkg::wb_req_t   req_i,
   output tile_pkg::wb_rsp_t   rsp_o,
   output tile_pkg::noc_flit_t noc_out_o,
   input  logic                noc_credit_i,
   input  tile_pkg::noc_flit_t noc_in_i,
   output logic                noc_credit_o
);

   localparam int CRW = $clog2(`TILE_NOC_CREDITS + 1);

   logic                ack_q;
   logic                err_q;
   logic [`TILE_DW-1:0] dat_q;
   logic [CRW-1:0]      credits_q;
   logic                tx_valid_q;
   logic [`TILE_DW-1:0] tx_data_q;
   logic                credit_o_q;

   logic [27:0]         ofs;
   logic                active;
   logic                is_tx;
   logic                is_rx;
   logic                is_stat;
   logic                tx_go;
   logic                rx_go;
   logic                stat_go;
   logic                bad;

   logic [`TILE_DW-1:0] fifo_head;
   logic                fifo_empty;
   logic [CRW-1:0]      fifo_count;

   assign ofs     = req_i.adr[27:0];
   assign active  = req_i.cyc && req_i.stb && !(ack_q || err_q);
   assign is_tx   = (ofs == `TILE_NA_TX_OFS);
   assign is_rx   = (ofs == `TILE_NA_RX_OFS);
   assign is_stat = (ofs == `TILE_NA_STAT_OFS);

   assign tx_go   = active && req_i.we && is_tx && (credits_q != '0);  // Else stall
   assign rx_go   = active && !req_i.we && is_rx && !fifo_empty;
   assign stat_go = active && !req_i.we && is_stat;
   assign bad     = active && (req_i.we ? !is_tx
                                        : !(is_rx || is_stat) || (is_rx && fifo_empty));

   flit_fifo #(
      .DEPTH (`TILE_NOC_CREDITS)
   ) u_rx_fifo (
      .clk     (clk),
      .reset_i (reset_i),
      .push_i  (noc_in_i),
      .pop_i   (rx_go),
      .head_o  (fifo_head),
      .empty_o (fifo_empty),
      .count_o (fifo_count)
   );

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q      <= 1'b0;
         err_q      <= 1'b0;
         tx_valid_q <= 1'b0;
         credit_o_q <= 1'b0;
         credits_q  <= CRW'(`TILE_NOC_CREDITS);
      end else begin
         ack_q      <= tx_go || rx_go || stat_go;
         err_q      <= bad;
         tx_valid_q <= tx_go;                     // Flit leaves with the ack
         credit_o_q <= rx_go;                     // Freed FIFO slot
         credits_q  <= credits_q + CRW'(noc_credit_i) - CRW'(tx_go);
      end
   end

   always_ff @(posedge clk) begin
      if (tx_go) begin
         tx_data_q <= req_i.dat;
      end
      if (rx_go) begin
         dat_q <= fifo_head;
      end else if (stat_go) begin
         dat_q <= {16'h0, 8'(fifo_count), 8'(credits_q)};
      end
   end

   assign rsp_o        = '{ack: ack_q, err: err_q, dat: dat_q};
   assign noc_out_o    = '{valid: tx_valid_q, data: tx_data_q};
   assign noc_credit_o = credit_o_q;

   // Neighbor never returns more than it was sent
   a_credit_max: assert property (@(posedge clk) disable iff (reset_i)
      credits_q <= CRW'(`TILE_NOC_CREDITS));

endmodule

// ==== compute_tile.sv ====
/*
 * Compute tile top: bus, data memory, mailbox and boot ROM
 */

`include "tile_defs.svh"

module compute_tile (
   input  logic                                       clk,
   input  logic                                       reset_i,
   input  tile_pkg::wb_req_t [`TILE_NUM_MASTERS-1:0]  m_req_i,
   output tile_pkg::wb_rsp_t [`TILE_NUM_MASTERS-1:0]  m_rsp_o,
   input  tile_pkg::noc_flit_t                        noc_in_i,
   output logic                                       noc_credit_o,
   output tile_pkg::noc_flit_t                        noc_out_o,
   input  logic                                       noc_credit_i
);

   tile_pkg::wb_req_t [`TILE_NUM_SLAVES-1:0] s_req;
   tile_pkg::wb_rsp_t [`TILE_NUM_SLAVES-1:0] s_rsp;

   tile_bus u_bus (
      .clk     (clk),
      .reset_i (reset_i),
      .m_req_i (m_req_i),
      .m_rsp_o (m_rsp_o),
      .s_req_o (s_req),
      .s_rsp_i (s_rsp)
   );

   tile_sram u_sram (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (s_req[tile_pkg::SLV_SRAM]),
      .rsp_o   (s_rsp[tile_pkg::SLV_SRAM])
   );

   na_mailbox u_na (
      .clk          (clk),
      .reset_i      (reset_i),
      .req_i        (s_req[tile_pkg::SLV_NA]),
      .rsp_o        (s_rsp[tile_pkg::SLV_NA]),
      .noc_out_o    (noc_out_o),
      .noc_credit_i (noc_credit_i),
      .noc_in_i     (noc_in_i),
      .noc_credit_o (noc_credit_o)
   );

   boot_rom u_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (s_req[tile_pkg::SLV_ROM]),
      .rsp_o   (s_rsp[tile_pkg::SLV_ROM])
   );

endmodule

// ==== tb_compute_tile.sv ====
/*
 * Testbench for the compute tile: clock, reset, random bus masters,
 * reference model, compare tasks and a NoC partner
 */

`include "tile_defs.svh"

module tb_compute_tile;

   localparam int NM      = `TILE_NUM_MASTERS;
   localparam int IW      = $clog2(`TILE_SRAM_WORDS);
   localparam int TIMEOUT = 400;                       // Cycles per wait

   logic                       clk;
   logic                       reset_i;
   tile_pkg::wb_req_t [NM-1:0] m_req;
   tile_pkg::wb_rsp_t [NM-1:0] m_rsp;
   tile_pkg::wb_req_t          req_drv [NM];           // One driver per master
   tile_pkg::noc_flit_t        noc_in;
   tile_pkg::noc_flit_t        noc_out;
   logic                       noc_credit_in;
   logic                       noc_credit_out;

   logic [`TILE_DW-1:0] model_mem [`TILE_SRAM_WORDS];
   bit                  written [`TILE_SRAM_WORDS];
   logic [`TILE_DW-1:0] exp_tx [$];                     // Flits still to appear
   logic [`TILE_DW-1:0] exp_rx [$];                     // Flits sitting in the FIFO
   int                  tx_credits;
   int                  tx_pending;                     // Sent, credit not yet returned
   int                  rx_credits;
   int                  inject_n;
   int                  credit_pulses;
   bit                  hold;                           // Partner keeps TX credits

   compute_tile i_compute_tile (
      .clk          (clk),
      .reset_i      (reset_i),
      .m_req_i      (m_req),
      .m_rsp_o      (m_rsp),
      .noc_in_i     (noc_in),
      .noc_credit_o (noc_credit_out),
      .noc_out_o    (noc_out),
      .noc_credit_i (noc_credit_in)
   );

   for (genvar g = 0; g < NM; g++) begin : g_req
      assign m_req[g] = req_drv[g];
   end

   always #2 clk = ~clk;

   task automatic stop_run();
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_rsp(input string name, input tile_pkg::wb_rsp_t got,
                            input tile_pkg::wb_rsp_t exp, input bit chk_dat);
      if (got.ack !== exp.ack || got.err !== exp.err || (chk_dat && got.dat !== exp.dat)) begin
         $display("Fail t=%0t %s got ack=%b err=%b dat=%h exp ack=%b err=%b dat=%h",
                  $time, name, got.ack, got.err, got.dat, exp.ack, exp.err, exp.dat);
         stop_run();
      end
   endtask

   task automatic check_flit(input string name, input tile_pkg::noc_flit_t got,
                             input tile_pkg::noc_flit_t exp);
      if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
         $display("Fail t=%0t %s got valid=%b data=%h exp valid=%b data=%h",
                  $time, name, got.valid, got.data, exp.valid, exp.data);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail t=%0t %s got %b exp %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("Fail t=%0t %s got %0d exp %0d", $time, name, got, exp);
         stop_run();
      end
   endtask

   function automatic tile_pkg::wb_req_t make_req(input bit we, input logic [`TILE_DW-1:0] adr,
                                                 input logic [3:0] sel,
                                                 input logic [`TILE_DW-1:0] dat);
      return '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
   endfunction

   function automatic tile_pkg::wb_rsp_t make_rsp(input bit ack, input bit err,
                                                 input logic [`TILE_DW-1:0] dat);
      return '{ack: ack, err: err, dat: dat};
   endfunction

   function automatic string rsp_name(input int m);
      return $sformatf("m_rsp_o[%0d]", m);
   endfunction

   function automatic logic [`TILE_DW-1:0] na_adr(input int ofs);
      return {`TILE_NA_MATCH, 28'(ofs)};
   endfunction

   task automatic issue(input int m, input tile_pkg::wb_req_t req);
      @(posedge clk);
      req_drv[m] <= req;
   endtask

   task automatic wait_rsp(input int m, input string what, output tile_pkg::wb_rsp_t rsp);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         rsp = m_rsp[m];
         n++;
      end while (rsp.ack !== 1'b1 && rsp.err !== 1'b1 && n < TIMEOUT);
      if (rsp.ack !== 1'b1 && rsp.err !== 1'b1) begin
         $display("Timeout: master %0d got no ack or err for its %s", m, what);
         stop_run();
      end
   endtask

   task automatic release_req(input int m);
      @(posedge clk);
      req_drv[m] <= '0;                                // End of the bus cycle
   endtask

   task automatic access(input int m, input tile_pkg::wb_req_t req,
                         output tile_pkg::wb_rsp_t rsp);
      issue(m, req);
      wait_rsp(m, req.we ? "write" : "read", rsp);
      release_req(m);
   endtask

   task automatic wait_idle(input string what);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while ((tx_pending != 0 || inject_n != 0) && n < TIMEOUT);
      if (tx_pending != 0 || inject_n != 0) begin
         $display("Timeout: NoC partner still busy %s", what);
         stop_run();
      end
   endtask

   // Random address inside the region, picked word index in the alias bits
   task automatic sram_op(input int m, input int idx);
      logic [`TILE_DW-1:0] adr;
      logic [`TILE_DW-1:0] data;
      logic [3:0]          sel;
      bit                  we;
      tile_pkg::wb_rsp_t   rsp;
      we          = !written[idx] || ($urandom_range(1, 0) == 1);
      adr         = {`TILE_SRAM_MATCH, 28'($urandom())};
      adr[IW+1:2] = IW'(idx);
      data        = $urandom();
      sel         = written[idx] ? 4'($urandom()) : 4'hf;  // Whole word on first use
      access(m, make_req(we, adr, sel, data), rsp);
      if (we) begin
         check_rsp(rsp_name(m), rsp, make_rsp(1'b1, 1'b0, '0), 1'b0);
         for (int b = 0; b < `TILE_DW / 8; b++) begin
            if (sel[b]) begin
               model_mem[idx][b*8 +: 8] = data[b*8 +: 8];
            end
         end
         written[idx] = 1'b1;
      end else begin
         check_rsp(rsp_name(m), rsp, make_rsp(1'b1, 1'b0, model_mem[idx]), 1'b1);
      end
   endtask

   task automatic rom_access(input int m, input bit we);
      logic [`TILE_DW-1:0] adr;
      logic [`TILE_DW-1:0] k;
      tile_pkg::wb_rsp_t   rsp;
      adr = {`TILE_ROM_MATCH, 28'($urandom())};
      k   = (adr >> 2) % `TILE_ROM_WORDS;
      access(m, make_req(we, adr, 4'hf, $urandom()), rsp);
      check_rsp(rsp_name(m), rsp, make_rsp(!we, we, `TILE_BOOT_MAGIC | k), !we);
   endtask

   task automatic bad_access(input int m);
      tile_pkg::wb_rsp_t rsp;
      access(m, make_req($urandom_range(1, 0), {4'($urandom_range(13, 1)), 28'($urandom())},
                         4'hf, $urandom()), rsp);
      check_rsp(rsp_name(m), rsp, make_rsp(1'b0, 1'b1, '0), 1'b0);
   endtask

   task automatic na_read(input int m, input int ofs, input tile_pkg::wb_rsp_t exp,
                          input bit chk_dat);
      tile_pkg::wb_rsp_t rsp;
      access(m, make_req(1'b0, na_adr(ofs), 4'hf, '0), rsp);
      check_rsp(rsp_name(m), rsp, exp, chk_dat);
   endtask

   // FIFO count in bits 15:8, transmit credits in bits 7:0
   task automatic stat_read(input int m);
      na_read(m, `TILE_NA_STAT_OFS,
              make_rsp(1'b1, 1'b0, {16'h0, 8'(exp_rx.size()), 8'(tx_credits)}), 1'b1);
   endtask

   task automatic tx_write(input int m, input bit stall);
      logic [`TILE_DW-1:0] data;
      tile_pkg::wb_rsp_t   rsp;
      data = $urandom();
      exp_tx.push_back(data);
      issue(m, make_req(1'b1, na_adr(`TILE_NA_TX_OFS), 4'hf, data));
      if (stall) begin
         repeat (12) begin
            @(negedge clk);
            check_rsp(rsp_name(m), m_rsp[m], '0, 1'b0);
            check_flit("noc_out_o", noc_out, '0);
         end
         hold = 1'b0;                                  // Let one credit come back
      end
      wait_rsp(m, "TX write", rsp);
      check_flit("noc_out_o", noc_out, '{valid: 1'b1, data: data});
      release_req(m);
      check_rsp(rsp_name(m), rsp, make_rsp(1'b1, 1'b0, '0), 1'b0);
      tx_credits--;
   endtask

   task automatic traffic(input int m);
      repeat (40) begin
         case ($urandom_range(4, 0))
            0: rom_access(m, 1'b0);
            1: bad_access(m);
            2: begin
               if (m == 0) begin
                  tx_write(m, 1'b0);                   // Single TX master keeps flit order
               end else begin
                  rom_access(m, 1'b1);
               end
            end
            default: sram_op(m, m * 32 + $urandom_range(15, 0));
         endcase
      end
   endtask

   // Neighbor tile: injects flits within its credits, returns TX credits late
   task automatic noc_partner();
      logic [`TILE_DW-1:0] data;
      forever begin
         @(posedge clk);
         noc_in        <= '0;
         noc_credit_in <= 1'b0;
         if (inject_n > 0 && rx_credits > 0 && $urandom_range(1, 0) == 1) begin
            data = $urandom();
            noc_in <= '{valid: 1'b1, data: data};
            exp_rx.push_back(data);
            rx_credits--;
            inject_n--;
         end
         if (!hold && tx_pending > 0 && $urandom_range(3, 0) == 0) begin
            noc_credit_in <= 1'b1;
            tx_pending--;
            tx_credits++;
         end
      end
   endtask

   always @(negedge clk) begin
      if (!reset_i) begin
         if (noc_out.valid === 1'b1) begin
            if (exp_tx.size() == 0) begin
               $display("Unexpected flit %h on noc_out_o at t=%0t", noc_out.data, $time);
               stop_run();
            end else begin
               check_flit("noc_out_o", noc_out, '{valid: 1'b1, data: exp_tx.pop_front()});
               tx_pending++;
            end
         end
         if (noc_credit_out === 1'b1) begin
            credit_pulses++;
            rx_credits++;
         end
      end
   end

   initial begin
      void'($urandom(85796));
      clk           = 1'b0;
      reset_i       = 1'b1;
      noc_in        = '0;
      noc_credit_in = 1'b0;
      hold          = 1'b0;
      tx_credits    = `TILE_NOC_CREDITS;
      tx_pending    = 0;
      rx_credits    = `TILE_NOC_CREDITS;
      inject_n      = 0;
      credit_pulses = 0;
      for (int m = 0; m < NM; m++) begin
         req_drv[m] = '0;
      end
      repeat (3) @(posedge clk);
      reset_i <= 1'b0;
      fork
         noc_partner();
      join_none

      @(negedge clk);                                  // Idle outputs after reset
      for (int m = 0; m < NM; m++) begin
         check_rsp(rsp_name(m), m_rsp[m], '0, 1'b0);
      end
      check_flit("noc_out_o", noc_out, '0);
      check_bit("noc_credit_o", noc_credit_out, 1'b0);
      stat_read(0);

      for (int i = 0; i < 40; i++) begin
         sram_op($urandom_range(NM - 1, 0), $urandom_range(15, 0));
      end

      repeat (6) rom_access($urandom_range(NM - 1, 0), 1'b0);
      rom_access(0, 1'b1);
      bad_access(1);
      sram_op(1, 3);
      rom_access(0, 1'b0);

      // TX order, then a write beyond the credits while the partner holds them
      wait_idle("before TX credit test");
      hold = 1'b1;
      repeat (`TILE_NOC_CREDITS) tx_write(0, 1'b0);
      stat_read(1);
      tx_write(0, 1'b1);
      wait_idle("after TX credit test");

      @(negedge clk);
      inject_n = `TILE_NOC_CREDITS;                    // Fill the receive FIFO
      wait_idle("while injecting flits");
      stat_read(0);
      repeat (`TILE_NOC_CREDITS) begin
         na_read($urandom_range(NM - 1, 0), `TILE_NA_RX_OFS,
                 make_rsp(1'b1, 1'b0, exp_rx.pop_front()), 1'b1);
      end
      check_count("noc_credit_o pulses", credit_pulses, `TILE_NOC_CREDITS);
      na_read(1, `TILE_NA_RX_OFS, make_rsp(1'b0, 1'b1, '0), 1'b0);
      stat_read(1);

      fork
         traffic(0);
         traffic(1);
      join
      wait_idle("after concurrent traffic");
      check_count("flits missing on noc_out_o", exp_tx.size(), 0);
      stat_read(0);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+.
tile_pkg.sv
tile_bus.sv
tile_sram.sv
boot_rom.sv
flit_fifo.sv
na_mailbox.sv
compute_tile.sv
tb_compute_tile.sv
